// File: rtl/ext_addr_map_pkg.sv
// ######################################
// External bus address map
// Slow-memory window placement and size
// ######################################

package ext_addr_map_pkg;

  // Word index covers 128 words
  localparam int unsigned word_idx_w = 7;

  localparam logic [31:0] slow_mem_base = 32'h0002_0000;

  // Window size in bytes, four bytes per word
  localparam logic [31:0] slow_mem_size = 32'((2 ** word_idx_w) * 4);

endpackage

// File: rtl/ext_bus_pkg.sv
// ######################################
// External bus types
// Widths and request/response payloads
// ######################################

package ext_bus_pkg;

  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;
  localparam int unsigned be_w   = 4;

  typedef struct packed {
    logic                                    we;
    logic [ext_addr_map_pkg::word_idx_w-1:0] idx;
    logic [be_w-1:0]                         be;
    logic [data_w-1:0]                       wdata;
    // Set by decode for addresses outside the window
    logic                                    err;
  } mem_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              err;
  } mem_rsp_t;

endpackage

// File: rtl/mem_chan_if.sv
// ######################################
// Memory channels
// Credit-based request and response links
// ######################################

`timescale 1ns/1ns

// Decode to memory
interface mem_req_if
  import ext_bus_pkg::*;
();

  logic     valid;
  mem_req_t req;
  logic     credit;

  modport src (
    output valid,
    output req,
    input  credit
  );

  modport dst (
    input  valid,
    input  req,
    output credit
  );

endinterface

// Memory to response buffer
interface mem_rsp_if
  import ext_bus_pkg::*;
();

  logic     valid;
  mem_rsp_t rsp;
  logic     credit;

  modport src (
    output valid,
    output rsp,
    input  credit
  );

  modport dst (
    input  valid,
    input  rsp,
    output credit
  );

endinterface

// File: rtl/credit_fifo.sv
// ######################################
// Credit FIFO
// Circular buffer, one credit per pop
// ######################################

`timescale 1ns/1ns

module credit_fifo #(
  parameter type         item_t = logic,
  parameter int unsigned depth  = 4
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  push_i,
  input  item_t data_i,
  input  logic  pop_i,
  output item_t data_o,
  output logic  empty_o,
  output logic  credit_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  item_t            slot_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q  <= count_q + cnt_w'(push_i) - cnt_w'(pop_i);
      // Freed slot goes back to the sender next cycle
      credit_o <= pop_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      slot_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = slot_q[rd_ptr_q];
  assign empty_o = (count_q == '0);

  // Sender credit count must keep pushes within free slots
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(push_i && count_q == cnt_w'(depth)) && !(pop_i && empty_o));

endmodule

// File: rtl/ext_bus_decode.sv
// ######################################
// External bus decode
// Window check and request issue
// ######################################

`timescale 1ns/1ns

module ext_bus_decode
  import ext_bus_pkg::*;
  import ext_addr_map_pkg::*;
#(
  parameter int unsigned req_depth = 4
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [addr_w-1:0] addr_i,
  input  logic [be_w-1:0]   be_i,
  input  logic [data_w-1:0] wdata_i,
  output logic              gnt_o,
  mem_req_if.src            req_chan
);

  localparam int unsigned       cnt_w   = $clog2(req_depth + 1);
  localparam logic [addr_w-1:0] win_end = slow_mem_base + slow_mem_size;

  logic [cnt_w-1:0] credit_cnt_q;
  logic             accept;
  logic             in_window;
  logic             valid_q;
  mem_req_t         req_q;

  assign gnt_o     = (credit_cnt_q != '0);
  assign accept    = req_i && gnt_o;
  assign in_window = (addr_i >= slow_mem_base) && (addr_i < win_end);

  // Credit is taken at accept, one cycle ahead of the beat
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_cnt_q <= cnt_w'(req_depth);
      valid_q      <= 1'b0;
    end else begin
      credit_cnt_q <= credit_cnt_q + cnt_w'(req_chan.credit) - cnt_w'(accept);
      valid_q      <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.we    <= we_i;
      req_q.idx   <= addr_i[word_idx_w+1:2];
      req_q.be    <= be_i;
      req_q.wdata <= wdata_i;
      req_q.err   <= !in_window;
    end
  end

  assign req_chan.valid = valid_q;
  assign req_chan.req   = req_q;

  // Memory never returns more credits than its queue holds
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_cnt_q <= cnt_w'(req_depth));

endmodule

// File: rtl/slow_memory.sv
// ######################################
// Slow memory
// Queued word memory with byte enables
// ######################################

`timescale 1ns/1ns

module slow_memory
  import ext_bus_pkg::*;
#(
  parameter int unsigned num_words = 128,
  parameter int unsigned req_depth = 4,
  parameter int unsigned rsp_depth = 2
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  mem_req_if.dst req_chan,
  mem_rsp_if.src rsp_chan
);

  localparam int unsigned cnt_w = $clog2(rsp_depth + 1);

  logic [data_w-1:0] mem_q [num_words];
  mem_req_t          head;
  logic              head_empty;
  logic              exec;
  logic [cnt_w-1:0]  rsp_cnt_q;
  logic              rsp_valid_q;
  mem_rsp_t          rsp_q;

  credit_fifo #(
    .item_t(mem_req_t),
    .depth (req_depth)
  ) req_fifo_i (
    .clk_i,
    .arst_n_i,
    .push_i  (req_chan.valid),
    .data_i  (req_chan.req),
    .pop_i   (exec),
    .data_o  (head),
    .empty_o (head_empty),
    .credit_o(req_chan.credit)
  );

  // Head waits while no response slot is free
  assign exec = !head_empty && (rsp_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (exec && head.we && !head.err) begin
      for (int b = 0; b < be_w; b++) begin
        if (head.be[b]) begin
          mem_q[head.idx][b*8 +: 8] <= head.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Writes and errors return zero data
  always_ff @(posedge clk_i) begin
    if (exec) begin
      rsp_q.err   <= head.err;
      rsp_q.rdata <= (head.we || head.err) ? '0 : mem_q[head.idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_cnt_q   <= cnt_w'(rsp_depth);
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_cnt_q   <= rsp_cnt_q + cnt_w'(rsp_chan.credit) - cnt_w'(exec);
      rsp_valid_q <= exec;
    end
  end

  assign rsp_chan.valid = rsp_valid_q;
  assign rsp_chan.rsp   = rsp_q;

  // Response buffer credits stay within its depth
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_cnt_q <= cnt_w'(rsp_depth));

endmodule

// File: rtl/bus_response.sv
// ######################################
// Bus response buffer
// Queued responses under ready stall
// ######################################

`timescale 1ns/1ns

module bus_response
  import ext_bus_pkg::*;
#(
  parameter int unsigned rsp_depth = 2
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  mem_rsp_if.dst            rsp_chan,
  input  logic              rready_i,
  output logic              rvalid_o,
  output logic [data_w-1:0] rdata_o,
  output logic              err_o
);

  mem_rsp_t head;
  logic     head_empty;
  logic     consume;

  assign consume = rvalid_o && rready_i;

  // Popping the head hands the credit back to the memory
  credit_fifo #(
    .item_t(mem_rsp_t),
    .depth (rsp_depth)
  ) rsp_fifo_i (
    .clk_i,
    .arst_n_i,
    .push_i  (rsp_chan.valid),
    .data_i  (rsp_chan.rsp),
    .pop_i   (consume),
    .data_o  (head),
    .empty_o (head_empty),
    .credit_o(rsp_chan.credit)
  );

  assign rvalid_o = !head_empty;
  assign rdata_o  = head.rdata;
  assign err_o    = head.err;

  // Stalled response holds until taken
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(err_o));

endmodule

// File: rtl/power_switch_model.sv
// ######################################
// Power switch model
// Fixed-delay switch acknowledge
// ######################################

`timescale 1ns/1ns

module power_switch_model #(
  parameter int unsigned switch_ack_latency = 15,
  parameter int unsigned num_domains        = 3
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [num_domains-1:0] switch_n_i,
  output logic [num_domains-1:0] ack_n_o
);

  // One bit per domain in each stage, all switched off at reset
  logic [num_domains-1:0] stage_q [switch_ack_latency];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < switch_ack_latency; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < switch_ack_latency; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign ack_n_o = stage_q[switch_ack_latency-1];

endmodule

// File: rtl/ext_periph_subsys.sv
// ######################################
// External peripheral subsystem
// Slow-memory bus and power-switch model
// ######################################

`timescale 1ns/1ns

module ext_periph_subsys
  import ext_bus_pkg::*;
#(
  parameter int unsigned num_words          = 128,
  parameter int unsigned req_depth          = 4,
  parameter int unsigned rsp_depth          = 2,
  parameter int unsigned switch_ack_latency = 15,
  parameter int unsigned num_domains        = 3
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [addr_w-1:0]      addr_i,
  input  logic [be_w-1:0]        be_i,
  input  logic [data_w-1:0]      wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [data_w-1:0]      rdata_o,
  output logic                   err_o,
  input  logic                   rready_i,
  input  logic [num_domains-1:0] switch_n_i,
  output logic [num_domains-1:0] ack_n_o
);

  mem_req_if req_chan ();
  mem_rsp_if rsp_chan ();

  ext_bus_decode #(
    .req_depth(req_depth)
  ) ext_bus_decode_i (
    .clk_i,
    .arst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .req_chan(req_chan)
  );

  slow_memory #(
    .num_words(num_words),
    .req_depth(req_depth),
    .rsp_depth(rsp_depth)
  ) slow_memory_i (
    .clk_i,
    .arst_n_i,
    .req_chan(req_chan),
    .rsp_chan(rsp_chan)
  );

  bus_response #(
    .rsp_depth(rsp_depth)
  ) bus_response_i (
    .clk_i,
    .arst_n_i,
    .rsp_chan(rsp_chan),
    .rready_i,
    .rvalid_o,
    .rdata_o,
    .err_o
  );

  // Stand-in for the switch cells of the external domains
  power_switch_model #(
    .switch_ack_latency(switch_ack_latency),
    .num_domains       (num_domains)
  ) power_switch_model_i (
    .clk_i,
    .arst_n_i,
    .switch_n_i,
    .ack_n_o
  );

endmodule

// File: sim/tb_ext_periph_subsys.sv
// ######################################
// External peripheral subsystem testbench
// Table-driven bus and switch-ack checks
// ######################################

`timescale 1ns/1ns

module tb_ext_periph_subsys
  import ext_bus_pkg::*;
  import ext_addr_map_pkg::*;
();

  localparam int unsigned num_words          = 128;
  localparam int unsigned req_depth          = 4;
  localparam int unsigned rsp_depth          = 2;
  localparam int unsigned switch_ack_latency = 15;
  localparam int unsigned num_domains        = 3;
  localparam int          wait_limit         = 200;

  typedef struct {
    logic              we;
    logic [addr_w-1:0] addr;
    logic [be_w-1:0]   be;
    logic [data_w-1:0] wdata;
    logic [data_w-1:0] exp_rdata;
    logic              exp_err;
  } entry_t;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   req_i;
  logic                   we_i;
  logic [addr_w-1:0]      addr_i;
  logic [be_w-1:0]        be_i;
  logic [data_w-1:0]      wdata_i;
  logic                   gnt_o;
  logic                   rvalid_o;
  logic [data_w-1:0]      rdata_o;
  logic                   err_o;
  logic                   rready_i;
  logic [num_domains-1:0] switch_n_i;
  logic [num_domains-1:0] ack_n_o;

  entry_t                 stim_q [$];
  logic [num_domains-1:0] sw_log [$];
  int                     err_count;
  int                     timeout_count;
  logic                   timed_out;
  logic                   traffic_on;
  logic                   gnt_low_seen;
  logic                   gnt_high_again;

  ext_periph_subsys #(
    .num_words         (num_words),
    .req_depth         (req_depth),
    .rsp_depth         (rsp_depth),
    .switch_ack_latency(switch_ack_latency),
    .num_domains       (num_domains)
  ) ext_periph_subsys_i (
    .clk_i,
    .arst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .err_o,
    .rready_i,
    .switch_n_i,
    .ack_n_o
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // Switch inputs seen at each rising edge out of reset
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      sw_log.push_back(switch_n_i);
    end
  end

  always @(negedge clk_i) begin
    if (traffic_on) begin
      if (!gnt_o) begin
        gnt_low_seen = 1'b1;
      end else if (gnt_low_seen) begin
        gnt_high_again = 1'b1;
      end
    end
  end

  function automatic void add_entry(input logic we, input logic [addr_w-1:0] addr,
                                    input logic [be_w-1:0] be, input logic [data_w-1:0] wdata,
                                    input logic [data_w-1:0] exp_rdata, input logic exp_err);
    entry_t e;
    e.we        = we;
    e.addr      = addr;
    e.be        = be;
    e.wdata     = wdata;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    stim_q.push_back(e);
  endfunction

  // Ack lags the switch by the full delay line
  function automatic logic [num_domains-1:0] delayed_switch();
    if (sw_log.size() < switch_ack_latency) begin
      return '1;
    end
    return sw_log[sw_log.size() - switch_ack_latency];
  endfunction

  task automatic send_requests();
    int waited;
    for (int i = 0; i < stim_q.size() && !timed_out; i++) begin
      waited = 0;
      @(negedge clk_i);
      while (!gnt_o && !timed_out) begin
        req_i = 1'b0;
        waited++;
        if (waited > wait_limit) begin
          $display("timeout: no grant for request %0d", i);
          timed_out = 1'b1;
          timeout_count++;
        end else begin
          @(negedge clk_i);
        end
      end
      if (!timed_out) begin
        req_i   = 1'b1;
        we_i    = stim_q[i].we;
        addr_i  = stim_q[i].addr;
        be_i    = stim_q[i].be;
        wdata_i = stim_q[i].wdata;
      end
    end
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  task automatic check_responses();
    int   waited;
    int   stall;
    logic done;
    stall = 20;
    for (int i = 0; i < stim_q.size() && !timed_out; i++) begin
      waited = 0;
      done   = 1'b0;
      // Second long stall halfway through
      if (i == 8) begin
        stall = 20;
      end
      while (!done && !timed_out) begin
        @(negedge clk_i);
        if (stall > 0) begin
          rready_i = 1'b0;
          stall--;
        end else begin
          rready_i = 1'($urandom_range(1, 0));
        end
        if (rvalid_o && rready_i) begin
          done = 1'b1;
          if (rdata_o !== stim_q[i].exp_rdata || err_o !== stim_q[i].exp_err) begin
            $display("error at %0t ns: response %0d rdata %h err %b, expected %h %b",
                     $time, i, rdata_o, err_o, stim_q[i].exp_rdata, stim_q[i].exp_err);
            err_count++;
          end
        end else begin
          waited++;
          if (waited > wait_limit) begin
            $display("timeout: response %0d never arrived", i);
            timed_out = 1'b1;
            timeout_count++;
          end
        end
      end
    end
    @(negedge clk_i);
    rready_i = 1'b0;
  endtask

  task automatic check_switch_ack();
    for (int c = 0; c < 80; c++) begin
      @(negedge clk_i);
      if (ack_n_o !== delayed_switch()) begin
        $display("error at %0t ns: ack_n_o %b, expected %b", $time, ack_n_o, delayed_switch());
        err_count++;
      end
      // Each domain in turn
      if (c < 60 && c % 5 == 0) begin
        switch_n_i[(c / 5) % num_domains] ^= 1'b1;
      end
    end
  endtask

  initial begin
    void'($urandom(32'h5221684b));
    err_count      = 0;
    timeout_count  = 0;
    timed_out      = 1'b0;
    traffic_on     = 1'b0;
    gnt_low_seen   = 1'b0;
    gnt_high_again = 1'b0;
    arst_n_i       = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    rready_i       = 1'b0;
    switch_n_i     = '1;

    add_entry(1'b1, slow_mem_base + 32'h000, 4'hf, 32'h1122_3344, 32'h0, 1'b0);
    add_entry(1'b1, slow_mem_base + 32'h004, 4'hf, 32'ha5a5_5a5a, 32'h0, 1'b0);
    add_entry(1'b1, slow_mem_base + 32'h1fc, 4'hf, 32'hdead_beef, 32'h0, 1'b0);
    add_entry(1'b1, slow_mem_base + 32'h040, 4'hf, 32'h0123_4567, 32'h0, 1'b0);
    add_entry(1'b0, slow_mem_base + 32'h000, 4'hf, 32'h0, 32'h1122_3344, 1'b0);
    add_entry(1'b0, slow_mem_base + 32'h004, 4'hf, 32'h0, 32'ha5a5_5a5a, 1'b0);
    add_entry(1'b0, slow_mem_base + 32'h1fc, 4'hf, 32'h0, 32'hdead_beef, 1'b0);
    add_entry(1'b1, slow_mem_base + 32'h040, 4'h5, 32'hffee_ddcc, 32'h0, 1'b0);
    add_entry(1'b0, slow_mem_base + 32'h040, 4'hf, 32'h0, 32'h01ee_45cc, 1'b0);
    // Just below the window and just past its end
    add_entry(1'b1, slow_mem_base - 32'h004, 4'hf, 32'h9999_9999, 32'h0, 1'b1);
    add_entry(1'b1, slow_mem_base + 32'h200, 4'hf, 32'h7777_7777, 32'h0, 1'b1);
    add_entry(1'b0, slow_mem_base + 32'h000, 4'hf, 32'h0, 32'h1122_3344, 1'b0);
    add_entry(1'b0, 32'h0000_0000, 4'hf, 32'h0, 32'h0, 1'b1);
    add_entry(1'b1, slow_mem_base + 32'h004, 4'h8, 32'hcc00_0000, 32'h0, 1'b0);
    add_entry(1'b0, slow_mem_base + 32'h004, 4'hf, 32'h0, 32'hcca5_5a5a, 1'b0);
    add_entry(1'b0, slow_mem_base + 32'h1fc, 4'hf, 32'h0, 32'hdead_beef, 1'b0);
    add_entry(1'b0, slow_mem_base + 32'h040, 4'hf, 32'h0, 32'h01ee_45cc, 1'b0);

    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    if (rvalid_o !== 1'b0 || gnt_o !== 1'b1 || ack_n_o !== '1) begin
      $display("error at %0t ns: reset state rvalid %b gnt %b ack_n %b",
               $time, rvalid_o, gnt_o, ack_n_o);
      err_count++;
    end

    traffic_on = 1'b1;
    fork
      send_requests();
      check_responses();
    join
    traffic_on = 1'b0;
    if (!timed_out && (!gnt_low_seen || !gnt_high_again)) begin
      $display("error at %0t ns: gnt_o low seen %b, high again %b",
               $time, gnt_low_seen, gnt_high_again);
      err_count++;
    end

    if (!timed_out) begin
      check_switch_ack();
    end

    $display("%0d value errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
rtl/ext_addr_map_pkg.sv
rtl/ext_bus_pkg.sv
rtl/mem_chan_if.sv
rtl/credit_fifo.sv
rtl/ext_bus_decode.sv
rtl/slow_memory.sv
rtl/bus_response.sv
rtl/power_switch_model.sv
rtl/ext_periph_subsys.sv
sim/tb_ext_periph_subsys.sv

// File: Bender.yml
package:
  name: ext_periph_subsys

sources:
  - rtl/ext_addr_map_pkg.sv
  - rtl/ext_bus_pkg.sv
  - rtl/mem_chan_if.sv
  - rtl/credit_fifo.sv
  - rtl/ext_bus_decode.sv
  - rtl/slow_memory.sv
  - rtl/bus_response.sv
  - rtl/power_switch_model.sv
  - rtl/ext_periph_subsys.sv
  - target: test
    files:
      - sim/tb_ext_periph_subsys.sv
